// File: memPkg.sv
//----------------------------------------------------------
// Memory stage package
// Cache geometry, MIPS load and store opcodes and the packed
// structs passed between the access decoder, the data cache
// arrays and the data cache controller
//----------------------------------------------------------

package memPkg;

   //----------------------------------------------------------
   // Geometry
   //----------------------------------------------------------

   // Data and address width
   localparam int wordWidth = 32;
   localparam int byteLanes = wordWidth / 8;

   // Four words per line, 16 sets, two ways
   localparam int offsetWidth  = 2;
   localparam int wordsPerLine = 1 << offsetWidth;
   localparam int indexWidth   = 4;
   localparam int numSets      = 1 << indexWidth;
   localparam int tagWidth     = wordWidth - indexWidth - offsetWidth - 2;
   localparam int numWays      = 2;
   localparam int wayWidth     = $clog2(numWays);

   //----------------------------------------------------------
   // MIPS major opcodes
   //----------------------------------------------------------

   localparam logic [5:0] opLw  = 6'h23;
   localparam logic [5:0] opLh  = 6'h21;
   localparam logic [5:0] opLhu = 6'h25;
   localparam logic [5:0] opLb  = 6'h20;
   localparam logic [5:0] opLbu = 6'h24;
   localparam logic [5:0] opSw  = 6'h2B;
   localparam logic [5:0] opSh  = 6'h29;
   localparam logic [5:0] opSb  = 6'h28;

   typedef enum logic [1:0] {
      sizeByte,
      sizeHalf,
      sizeWord
   } accessSize_t;

   //----------------------------------------------------------
   // Shared structs
   //----------------------------------------------------------

   // Byte address split into cache fields
   typedef struct packed {
      logic [tagWidth-1:0]    tag;
      logic [indexWidth-1:0]  index;
      logic [offsetWidth-1:0] offset;
      logic [1:0]             byteSel;
   } cacheAddr_t;

   typedef struct packed {
      logic valid;
      logic dirty;
   } lineState_t;

   // Decoded stage-four access, store data already in its lane
   typedef struct packed {
      logic                 isLoad;
      logic                 isStore;
      accessSize_t          size;
      logic [wayWidth-1:0]  victimWay;
      cacheAddr_t           addr;
      logic [wordWidth-1:0] storeWord;
      logic [byteLanes-1:0] byteEn;
   } memAccess_t;

   // One way at the addressed set and offset
   typedef struct packed {
      logic [tagWidth-1:0]  tag;
      lineState_t           state;
      logic [wordWidth-1:0] word;
   } wayView_t;

   typedef struct packed {
      logic [indexWidth-1:0]  index;
      logic [offsetWidth-1:0] offset;
   } arrayRead_t;

   // Tag, state and data writes share one position
   typedef struct packed {
      logic [wayWidth-1:0]    way;
      logic [indexWidth-1:0]  index;
      logic [offsetWidth-1:0] offset;
      logic                   dataWe;
      logic [byteLanes-1:0]   byteEn;
      logic [wordWidth-1:0]   wdata;
      logic                   tagWe;
      logic [tagWidth-1:0]    tag;
      logic                   stateWe;
      lineState_t             state;
   } arrayWrite_t;

   typedef struct packed {
      logic                 read;
      logic                 write;
      logic [wordWidth-1:0] addr;
      logic [wordWidth-1:0] wdata;
   } memReq_t;

endpackage

// File: memAccessDecode.sv
//----------------------------------------------------------
// Memory access decoder
// Turns the stage-four instruction and address into a load or
// store access, with store data moved into its big-endian
// byte lane and the matching byte enables
//----------------------------------------------------------

module memAccessDecode (
   input  logic [memPkg::wordWidth-1:0] instr,
   input  logic [memPkg::wordWidth-1:0] memAddr,
   input  logic [memPkg::wordWidth-1:0] storeData,
   output memPkg::memAccess_t           access
);
   import memPkg::*;

   logic [5:0]           opcode;
   cacheAddr_t           addr;
   logic                 isLoad;
   logic                 isStore;
   accessSize_t          size;
   logic [4:0]           laneShift;
   logic [wordWidth-1:0] storeWord;
   logic [byteLanes-1:0] byteEn;

   assign opcode = instr[31:26];
   assign addr   = memAddr;

   // Opcode decode
   always_comb begin
      isLoad  = 1'b0;
      isStore = 1'b0;
      size    = sizeWord;
      case (opcode)
         opLw: begin
            isLoad = 1'b1;
         end
         opLh, opLhu: begin
            isLoad = 1'b1;
            size   = sizeHalf;
         end
         opLb, opLbu: begin
            isLoad = 1'b1;
            size   = sizeByte;
         end
         opSw: begin
            isStore = 1'b1;
         end
         opSh: begin
            isStore = 1'b1;
            size    = sizeHalf;
         end
         opSb: begin
            isStore = 1'b1;
            size    = sizeByte;
         end
         default: begin
         end
      endcase
   end

   // Big-endian lanes, byteSel 0 is the most significant byte
   always_comb begin
      case (size)
         sizeByte: begin
            laneShift = {~addr.byteSel, 3'b000};
            storeWord = {{(wordWidth - 8){1'b0}}, storeData[7:0]} << laneShift;
            byteEn    = 4'b1000 >> addr.byteSel;
         end
         sizeHalf: begin
            // Only the upper byteSel bit picks the half
            laneShift = {~addr.byteSel[1], 4'b0000};
            storeWord = {{(wordWidth - 16){1'b0}}, storeData[15:0]} << laneShift;
            byteEn    = addr.byteSel[1] ? 4'b0011 : 4'b1100;
         end
         default: begin
            laneShift = 5'd0;
            storeWord = storeData;
            byteEn    = '1;
         end
      endcase
   end

   always_comb begin
      access.isLoad    = isLoad;
      access.isStore   = isStore;
      access.size      = size;
      // Victim way choice rides on instruction bit 20
      access.victimWay = instr[20];
      access.addr      = addr;
      access.storeWord = storeWord;
      access.byteEn    = byteEn;
   end

endmodule

// File: dcacheArrays.sv
//----------------------------------------------------------
// Data cache arrays
// Tag, state and data storage for every way. All ways are
// read combinationally at one set and word; a single write
// command updates one way at the next clock edge
//----------------------------------------------------------

module dcacheArrays (
   input  logic                CLK,
   input  logic                MRST,
   input  memPkg::arrayRead_t  arrRead,
   input  memPkg::arrayWrite_t arrWrite,
   output memPkg::wayView_t    ways [memPkg::numWays]
);
   import memPkg::*;

   localparam int wordsPerWay = numSets * wordsPerLine;

   logic [tagWidth-1:0]  tagMem   [numWays][numSets];
   lineState_t           stateMem [numWays][numSets];
   logic [wordWidth-1:0] dataMem  [numWays][wordsPerWay];

   // Word address inside one way is set then offset
   logic [indexWidth+offsetWidth-1:0] readWordAddr;
   logic [indexWidth+offsetWidth-1:0] writeWordAddr;

   assign readWordAddr  = {arrRead.index, arrRead.offset};
   assign writeWordAddr = {arrWrite.index, arrWrite.offset};

   //----------------------------------------------------------
   // Read side
   //----------------------------------------------------------

   always_comb begin
      for (int w = 0; w < numWays; w++) begin
         ways[w].tag   = tagMem[w][arrRead.index];
         ways[w].state = stateMem[w][arrRead.index];
         ways[w].word  = dataMem[w][readWordAddr];
      end
   end

   //----------------------------------------------------------
   // Write side
   //----------------------------------------------------------

   // Valid and dirty bits, cleared on reset
   always_ff @(posedge CLK) begin
      if (MRST) begin
         for (int w = 0; w < numWays; w++) begin
            for (int s = 0; s < numSets; s++) begin
               stateMem[w][s] <= '0;
            end
         end
      end
      else if (arrWrite.stateWe) begin
         stateMem[arrWrite.way][arrWrite.index] <= arrWrite.state;
      end
   end

   always_ff @(posedge CLK) begin
      if (arrWrite.tagWe) begin
         tagMem[arrWrite.way][arrWrite.index] <= arrWrite.tag;
      end
   end

   // Byte-enabled data write
   // Sub-word stores merge here with the bytes already in the line
   always_ff @(posedge CLK) begin
      if (arrWrite.dataWe) begin
         for (int b = 0; b < byteLanes; b++) begin
            if (arrWrite.byteEn[b]) begin
               dataMem[arrWrite.way][writeWordAddr][b*8 +: 8] <= arrWrite.wdata[b*8 +: 8];
            end
         end
      end
   end

endmodule

// File: dcacheControl.sv
//----------------------------------------------------------
// Data cache controller
// Hit detection, load data and pipeline stall, plus the FSM
// for store hits, dirty line write-back and line refill.
// The memory request is driven from the FSM state
//----------------------------------------------------------

module dcacheControl (
   input  logic                         CLK,
   input  logic                         MRST,
   input  memPkg::memAccess_t           access,
   input  memPkg::wayView_t             ways [memPkg::numWays],
   output memPkg::arrayRead_t           arrRead,
   output memPkg::arrayWrite_t          arrWrite,
   output logic [memPkg::wordWidth-1:0] loadData,
   output logic                         stall,
   output memPkg::memReq_t              memReq,
   input  logic                         memValid,
   input  logic [memPkg::wordWidth-1:0] memRdata
);
   import memPkg::*;

   typedef enum logic [2:0] {
      stIdle,
      stStoreHit,
      stWriteBack,
      stWaitMem,
      stRefill
   } fsmState_t;

   fsmState_t              fsmState;
   logic [offsetWidth-1:0] lineCount;

   logic [numWays-1:0]  hitVec;
   logic                hit;
   logic [wayWidth-1:0] hitWay;
   logic                memOp;
   lineState_t          victimState;
   logic                missDirty;
   logic                lastWord;
   logic                wbActive;
   cacheAddr_t          reqAddr;

   // Line under write-back or refill, and the pending store
   logic [tagWidth-1:0]   lineTag;
   logic [indexWidth-1:0] lineIndex;
   logic [wayWidth-1:0]   lineWay;
   arrayWrite_t           storeWrite;

   //----------------------------------------------------------
   // Hit detection and pipeline outputs
   //----------------------------------------------------------

   always_comb begin
      hitWay = '0;
      for (int w = 0; w < numWays; w++) begin
         hitVec[w] = ways[w].state.valid && (ways[w].tag == access.addr.tag);
         if (hitVec[w]) begin
            hitWay = wayWidth'(w);
         end
      end
   end

   assign hit         = |hitVec;
   assign memOp       = access.isLoad || access.isStore;
   assign victimState = ways[access.victimWay].state;
   assign missDirty   = victimState.valid && victimState.dirty;
   assign lastWord    = (lineCount == offsetWidth'(wordsPerLine - 1));
   assign wbActive    = (fsmState == stWriteBack);

   // Raw cache word, no sign extension
   assign loadData = (access.isLoad && hit) ? ways[hitWay].word : '0;

   // Any access stalls outside idle, including the store-hit cycle
   assign stall = memOp && ((fsmState != stIdle) || !hit);

   //----------------------------------------------------------
   // FSM
   //----------------------------------------------------------

   always_ff @(posedge CLK) begin
      if (MRST) begin
         fsmState  <= stIdle;
         lineCount <= '0;
      end
      else begin
         case (fsmState)
            stIdle: begin
               lineCount <= '0;
               if (memOp && !hit) begin
                  // Dirty victim goes out first, then the miss is seen again
                  fsmState <= missDirty ? stWriteBack : stWaitMem;
               end
               else if (access.isStore) begin
                  fsmState <= stStoreHit;
               end
            end
            stStoreHit: begin
               fsmState <= stIdle;
            end
            stWriteBack: begin
               // One word per cycle, memory never holds off
               lineCount <= lineCount + 1'b1;
               if (lastWord) begin
                  fsmState <= stIdle;
               end
            end
            stWaitMem: begin
               if (memValid) begin
                  lineCount <= lineCount + 1'b1;
                  fsmState  <= stRefill;
               end
            end
            stRefill: begin
               if (memValid) begin
                  lineCount <= lineCount + 1'b1;
                  if (lastWord) begin
                     fsmState <= stIdle;
                  end
               end
            end
            default: begin
               fsmState <= stIdle;
            end
         endcase
      end
   end

   // Captured in every idle cycle, used only after leaving idle
   always_ff @(posedge CLK) begin
      if (fsmState == stIdle) begin
         lineIndex <= access.addr.index;
         lineWay   <= access.victimWay;
         // Write-back addresses the old line, refill the new one
         lineTag   <= missDirty ? ways[access.victimWay].tag : access.addr.tag;

         storeWrite.way     <= hitWay;
         storeWrite.index   <= access.addr.index;
         storeWrite.offset  <= access.addr.offset;
         storeWrite.dataWe  <= 1'b1;
         storeWrite.byteEn  <= access.byteEn;
         storeWrite.wdata   <= access.storeWord;
         storeWrite.tagWe   <= 1'b0;
         storeWrite.tag     <= access.addr.tag;
         storeWrite.stateWe <= 1'b1;
         storeWrite.state   <= '{valid: 1'b1, dirty: 1'b1};
      end
   end

   //----------------------------------------------------------
   // Array control
   //----------------------------------------------------------

   // Write-back walks the victim line, otherwise follow the pipeline
   always_comb begin
      if (wbActive) begin
         arrRead.index  = lineIndex;
         arrRead.offset = lineCount;
      end
      else begin
         arrRead.index  = access.addr.index;
         arrRead.offset = access.addr.offset;
      end
   end

   always_comb begin
      arrWrite = '0;
      case (fsmState)
         stStoreHit: begin
            arrWrite = storeWrite;
         end
         stWriteBack: begin
            // Line is clean once the last word leaves
            arrWrite.way     = lineWay;
            arrWrite.index   = lineIndex;
            arrWrite.stateWe = lastWord;
            arrWrite.state   = '{valid: 1'b1, dirty: 1'b0};
         end
         stWaitMem, stRefill: begin
            arrWrite.way     = lineWay;
            arrWrite.index   = lineIndex;
            arrWrite.offset  = lineCount;
            arrWrite.dataWe  = memValid;
            arrWrite.byteEn  = '1;
            arrWrite.wdata   = memRdata;
            // Tag and state go in with the last word
            arrWrite.tagWe   = memValid && lastWord;
            arrWrite.tag     = lineTag;
            arrWrite.stateWe = memValid && lastWord;
            arrWrite.state   = '{valid: 1'b1, dirty: 1'b0};
         end
         default: begin
         end
      endcase
   end

   //----------------------------------------------------------
   // Memory request
   //----------------------------------------------------------

   // Refill address stays line aligned, write-back steps per word
   always_comb begin
      reqAddr.tag     = lineTag;
      reqAddr.index   = lineIndex;
      reqAddr.offset  = wbActive ? lineCount : '0;
      reqAddr.byteSel = 2'b00;

      memReq.read  = (fsmState == stWaitMem) || (fsmState == stRefill);
      memReq.write = wbActive;
      memReq.addr  = reqAddr;
      memReq.wdata = wbActive ? ways[lineWay].word : '0;
   end

endmodule

// File: memStage.sv
//----------------------------------------------------------
// Memory pipeline stage, data cache side
// Access decoder, two-way write-back data cache arrays and
// cache controller, with a private request port to memory
//----------------------------------------------------------

module memStage (
   input  logic                         CLK,
   input  logic                         MRST,
   input  logic [memPkg::wordWidth-1:0] instr,
   input  logic [memPkg::wordWidth-1:0] memAddr,
   input  logic [memPkg::wordWidth-1:0] storeData,
   output logic [memPkg::wordWidth-1:0] loadData,
   output logic                         stall,
   output memPkg::memReq_t              memReq,
   input  logic                         memValid,
   input  logic [memPkg::wordWidth-1:0] memRdata
);
   import memPkg::*;

   memAccess_t  access;
   arrayRead_t  arrRead;
   arrayWrite_t arrWrite;
   wayView_t    ways [numWays];

   // Stage-four instruction decode
   memAccessDecode decodeInst (
      .instr     (instr),
      .memAddr   (memAddr),
      .storeData (storeData),
      .access    (access)
   );

   // Tag, state and data storage
   dcacheArrays arraysInst (
      .CLK      (CLK),
      .MRST     (MRST),
      .arrRead  (arrRead),
      .arrWrite (arrWrite),
      .ways     (ways)
   );

   // Hit, stall and miss handling
   dcacheControl controlInst (
      .CLK      (CLK),
      .MRST     (MRST),
      .access   (access),
      .ways     (ways),
      .arrRead  (arrRead),
      .arrWrite (arrWrite),
      .loadData (loadData),
      .stall    (stall),
      .memReq   (memReq),
      .memValid (memValid),
      .memRdata (memRdata)
   );

endmodule

// File: tbMemoryModel.sv
//----------------------------------------------------------
// Testbench main memory
// 4096 words filled by an address rule. Refills are answered
// after a fixed delay with random gaps; write-back words are
// stored and logged
//----------------------------------------------------------

module tbMemoryModel (
   input  logic                         CLK,
   input  memPkg::memReq_t              memReq,
   output logic                         memValid,
   output logic [memPkg::wordWidth-1:0] memRdata
);
   timeunit 1ns;
   timeprecision 100ps;
   import memPkg::*;

   localparam int memWords = 4096;
   localparam int logDepth = 64;

   logic [31:0] mem   [memWords];
   logic [31:0] wbLog [logDepth];
   int          writeCount;
   int          runLen;
   logic        lastWrite;

   // Refill progress
   logic        reading;
   int          waitLeft;
   int          wordIdx;
   logic [15:0] lfsr;

   // Galois LFSR, taps 16, 14, 13, 11
   function automatic logic [15:0] galoisStep(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   initial begin
      for (int a = 0; a < memWords; a++) begin
         mem[a] = a * 3 + 32'h0005_1000;
      end
      memValid   = 1'b0;
      memRdata   = '0;
      writeCount = 0;
      runLen     = 0;
      lastWrite  = 1'b0;
      reading    = 1'b0;
      waitLeft   = 0;
      wordIdx    = 0;
      lfsr       = 16'd1593;
   end

   // Requests are stable on the falling edge
   always @(negedge CLK) begin
      // Write-back, one word per cycle
      if (memReq.write) begin
         mem[memReq.addr[13:2]] = memReq.wdata;
         if (writeCount < logDepth) begin
            wbLog[writeCount] = memReq.addr;
         end
         writeCount++;
         runLen = lastWrite ? runLen + 1 : 1;
      end
      lastWrite = memReq.write;

      // Refill with a start delay, then one LFSR bit per cycle
      if (!memReq.read) begin
         reading  = 1'b0;
         memValid = 1'b0;
      end
      else if (!reading) begin
         reading  = 1'b1;
         waitLeft = 2;
         wordIdx  = 0;
         memValid = 1'b0;
      end
      else if (waitLeft > 0) begin
         waitLeft--;
         memValid = 1'b0;
      end
      else if (wordIdx < wordsPerLine) begin
         // A one bit is a gap
         if (lfsr[0]) begin
            memValid = 1'b0;
         end
         else begin
            memValid = 1'b1;
            memRdata = mem[memReq.addr[13:2] + wordIdx];
            wordIdx++;
         end
         lfsr = galoisStep(lfsr);
      end
      else begin
         memValid = 1'b0;
      end
   end

endmodule

// File: tbMemStage.sv
//----------------------------------------------------------
// Memory stage testbench
// Directed loads and stores against the data cache, with
// refill, store merge, dirty write-back and clean eviction
//----------------------------------------------------------

module tbMemStage;
   timeunit 1ns;
   timeprecision 100ps;
   import memPkg::*;

   localparam time halfPeriod  = 20;
   localparam time sampleDelay = 10;
   // About 20 accesses with idle cycles between them, each well under 200 cycles
   localparam int  maxCycles   = 20 * 200;

   logic        CLK;
   logic        MRST;
   logic [31:0] instr;
   logic [31:0] memAddr;
   logic [31:0] storeData;
   logic [31:0] loadData;
   logic        stall;
   memReq_t     memReq;
   logic        memValid;
   logic [31:0] memRdata;

   int errorCount = 0;
   int checkCount = 0;
   int testsRun   = 0;
   int cycleCount = 0;

   memStage memStage_inst (
      .CLK       (CLK),
      .MRST      (MRST),
      .instr     (instr),
      .memAddr   (memAddr),
      .storeData (storeData),
      .loadData  (loadData),
      .stall     (stall),
      .memReq    (memReq),
      .memValid  (memValid),
      .memRdata  (memRdata)
   );

   tbMemoryModel memModel (
      .CLK      (CLK),
      .memReq   (memReq),
      .memValid (memValid),
      .memRdata (memRdata)
   );

   initial CLK = 1'b0;
   always #halfPeriod CLK = ~CLK;

   // Run limit
   always @(posedge CLK) begin
      cycleCount++;
      if (cycleCount >= maxCycles) begin
         $display("Timeout: tests did not finish within %0d cycles", maxCycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   //----------------------------------------------------------
   // Helpers
   //----------------------------------------------------------

   // Opcode in bits 31..26 and victim way in bit 20
   function automatic logic [31:0] makeInstr(input logic [5:0] op, input logic way);
      return {op, 5'd0, way, 20'd0};
   endfunction

   function automatic logic [31:0] memRule(input logic [31:0] byteAddr);
      return (byteAddr >> 2) * 3 + 32'h0005_1000;
   endfunction

   // Byte 0 is the top byte in big-endian order
   function automatic logic [31:0] mergeLane(input logic [31:0] old, input logic [31:0] data,
                                             input logic [1:0] byteSel, input accessSize_t size);
      logic [31:0] res;
      res = old;
      case (size)
         sizeByte: res[31 - 8 * byteSel -: 8] = data[7:0];
         sizeHalf: begin
            if (byteSel[1]) res[15:0] = data[15:0];
            else res[31:16] = data[15:0];
         end
         default:  res = data;
      endcase
      return res;
   endfunction

   task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] got);
      checkCount++;
      assert (got === exp) else begin
         $display("error at %0t: %s expected %h, got %h", $time, name, exp, got);
         errorCount++;
      end
   endtask

   // Present one access and wait for stall to drop
   task automatic applyAccess(input logic [31:0] ins, input logic [31:0] addr,
                              input logic [31:0] data, output logic firstStall);
      @(negedge CLK);
      instr     = ins;
      memAddr   = addr;
      storeData = data;
      #sampleDelay;
      firstStall = stall;
      while (stall) begin
         @(negedge CLK);
         #sampleDelay;
      end
   endtask

   task automatic driveNop();
      @(negedge CLK);
      instr = '0;
   endtask

   task automatic loadAndCompare(input logic [31:0] addr, input logic way,
                                 input logic [31:0] expData, output logic firstStall);
      applyAccess(makeInstr(opLw, way), addr, '0, firstStall);
      checkValue("loadData", expData, loadData);
      driveNop();
   endtask

   task automatic issueStore(input logic [5:0] op, input logic [31:0] addr,
                             input logic [31:0] data);
      logic firstStall;
      applyAccess(makeInstr(op, 1'b0), addr, data, firstStall);
      // Every store here goes to a cached line
      checkValue("stall on store hit", 0, firstStall);
      driveNop();
   endtask

   task automatic reportTest(input string name, input int startErrors);
      testsRun++;
      if (errorCount == startErrors) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, errorCount - startErrors);
   endtask

   //----------------------------------------------------------
   // Directed tests
   //----------------------------------------------------------

   task automatic idleAfterReset();
      int   startErrors;
      logic fs;
      startErrors = errorCount;
      #sampleDelay;
      checkValue("memReq.read", 0, memReq.read);
      checkValue("memReq.write", 0, memReq.write);
      checkValue("stall", 0, stall);
      // Non-memory opcode
      applyAccess(32'h0123_4567, 32'h0000_0100, '0, fs);
      checkValue("stall", 0, fs);
      driveNop();
      reportTest("reset and idle", startErrors);
   endtask

   task automatic loadMissRefill();
      int   startErrors;
      logic fs;
      startErrors = errorCount;
      loadAndCompare(32'h0100, 1'b0, memRule(32'h0100), fs);
      checkValue("stall on miss", 1, fs);
      // Another word of the same line
      loadAndCompare(32'h0108, 1'b0, memRule(32'h0108), fs);
      checkValue("stall on hit", 0, fs);
      reportTest("load miss and refill", startErrors);
   endtask

   task automatic storeMergeLanes();
      int          startErrors;
      logic        fs;
      logic [31:0] cur;
      startErrors = errorCount;
      cur = mergeLane(memRule(32'h0104), 32'h1122_3344, 2'd0, sizeWord);
      issueStore(opSw, 32'h0104, 32'h1122_3344);
      loadAndCompare(32'h0104, 1'b0, cur, fs);
      // Upper bits of store data must be ignored
      cur = mergeLane(cur, 32'h5555_AABB, 2'd2, sizeHalf);
      issueStore(opSh, 32'h0106, 32'h5555_AABB);
      loadAndCompare(32'h0104, 1'b0, cur, fs);
      cur = mergeLane(cur, 32'h7777_77CC, 2'd1, sizeByte);
      issueStore(opSb, 32'h0105, 32'h7777_77CC);
      loadAndCompare(32'h0104, 1'b0, cur, fs);
      reportTest("store merge", startErrors);
   endtask

   task automatic dirtyEviction();
      int   startErrors;
      int   wbStart;
      logic fs;
      startErrors = errorCount;
      // Fill both ways of set 3
      loadAndCompare(32'h0030, 1'b0, memRule(32'h0030), fs);
      loadAndCompare(32'h1030, 1'b1, memRule(32'h1030), fs);
      issueStore(opSw, 32'h0034, 32'hDEAD_BEEF);
      wbStart = memModel.writeCount;
      loadAndCompare(32'h2030, 1'b0, memRule(32'h2030), fs);
      checkValue("write cycles", 4, memModel.writeCount - wbStart);
      checkValue("write burst length", 4, memModel.runLen);
      for (int i = 0; i < 4; i++) begin
         checkValue("write-back addr", 32'h0030 + 4 * i, memModel.wbLog[wbStart + i]);
      end
      checkValue("memory word 0x34", 32'hDEAD_BEEF, memModel.mem[32'h0034 >> 2]);
      // Stored value comes back from memory
      loadAndCompare(32'h0034, 1'b0, 32'hDEAD_BEEF, fs);
      reportTest("dirty write-back", startErrors);
   endtask

   task automatic cleanEviction();
      int   startErrors;
      int   wbStart;
      logic fs;
      startErrors = errorCount;
      loadAndCompare(32'h0050, 1'b0, memRule(32'h0050), fs);
      loadAndCompare(32'h1050, 1'b1, memRule(32'h1050), fs);
      wbStart = memModel.writeCount;
      loadAndCompare(32'h2050, 1'b0, memRule(32'h2050), fs);
      checkValue("write cycles", 0, memModel.writeCount - wbStart);
      loadAndCompare(32'h1058, 1'b1, memRule(32'h1058), fs);
      checkValue("stall on hit", 0, fs);
      loadAndCompare(32'h205C, 1'b0, memRule(32'h205C), fs);
      checkValue("stall on hit", 0, fs);
      reportTest("clean eviction", startErrors);
   endtask

   //----------------------------------------------------------
   // Main sequence
   //----------------------------------------------------------

   initial begin
      MRST      = 1'b1;
      instr     = '0;
      memAddr   = '0;
      storeData = '0;
      repeat (4) @(posedge CLK);
      @(negedge CLK);
      MRST = 1'b0;

      idleAfterReset();
      loadMissRefill();
      storeMergeLanes();
      dirtyEviction();
      cleanEviction();

      $display("tests %0d, checks %0d, errors %0d", testsRun, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Simulation PASSED");
      end
      else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: sources.f
memPkg.sv
memAccessDecode.sv
dcacheArrays.sv
dcacheControl.sv
memStage.sv
tbMemoryModel.sv
tbMemStage.sv

// File: Bender.yml
package:
  name: memStage

sources:
  - memPkg.sv
  - memAccessDecode.sv
  - dcacheArrays.sv
  - dcacheControl.sv
  - memStage.sv
  - target: simulation
    files:
      - tbMemoryModel.sv
      - tbMemStage.sv
